// File: wb_mem_pkg.sv
package wb_mem_pkg;

  // bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int SEL_WIDTH  = DATA_WIDTH / 8;

  // ram holds 2**10 words, upper address bits alias
  localparam int MEM_INDEX_WIDTH = 10;

  // fetch queue sizing
  localparam int FETCH_QUEUE_DEPTH = 4;
  // count has to reach the full depth, hence the +1
  localparam int QUEUE_COUNT_WIDTH = $clog2(FETCH_QUEUE_DEPTH + 1);

  // words per fetch run
  localparam int LENGTH_WIDTH = 16;

  typedef logic [ADDR_WIDTH-1:0]        wb_addr_t;
  typedef logic [DATA_WIDTH-1:0]        wb_data_t;
  typedef logic [SEL_WIDTH-1:0]         wb_sel_t;
  typedef logic [MEM_INDEX_WIDTH-1:0]   mem_index_t;
  typedef logic [QUEUE_COUNT_WIDTH-1:0] queue_count_t;
  typedef logic [LENGTH_WIDTH-1:0]      run_length_t;

  // fetch unit states
  typedef enum logic [1:0]
  {
    FETCH_IDLE  = 2'd0,
    // issuing requests, may stall on credit
    FETCH_REQ   = 2'd1,
    // all requests out, waiting for responses
    FETCH_DRAIN = 2'd2
  } fetch_state_e;

endpackage

// File: dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
  input  logic                 clk,
  input  logic                 reset_i,

  // instruction port, read only
  input  logic                 inst_cyc_i,
  input  logic                 inst_stb_i,
  input  wb_mem_pkg::wb_addr_t inst_adr_i,
  output logic                 inst_ack_o,
  output wb_mem_pkg::wb_data_t inst_dat_o,

  // data port, byte-laned read/write
  input  logic                 data_cyc_i,
  input  logic                 data_stb_i,
  input  logic                 data_we_i,
  input  wb_mem_pkg::wb_addr_t data_adr_i,
  input  wb_mem_pkg::wb_sel_t  data_sel_i,
  input  wb_mem_pkg::wb_data_t data_dat_i,
  output logic                 data_ack_o,
  output wb_mem_pkg::wb_data_t data_dat_o
);
  import wb_mem_pkg::*;

  // byte offset bits sit below the word index
  localparam int OFFSET_BITS = $clog2(SEL_WIDTH);

  mem_index_t inst_idx;
  mem_index_t data_idx;
  logic       data_req;
  logic       data_wr;
  logic       inst_ack_q;
  logic       data_ack_q;

  // word index from the bits just above the byte offset
  // higher bits are dropped so addresses wrap
  assign inst_idx = inst_adr_i[OFFSET_BITS +: MEM_INDEX_WIDTH];
  assign data_idx = data_adr_i[OFFSET_BITS +: MEM_INDEX_WIDTH];

  assign data_req = data_cyc_i & data_stb_i;
  assign data_wr  = data_req & data_we_i;

  // one ack per request, exactly one cycle later, never stalls
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      inst_ack_q <= 1'b0;
      data_ack_q <= 1'b0;
    end
    else
    begin
      inst_ack_q <= inst_cyc_i & inst_stb_i;
      data_ack_q <= data_req;
    end
  end

  assign inst_ack_o = inst_ack_q;
  assign data_ack_o = data_ack_q;

  // one byte-wide array per lane
  for (genvar lane = 0; lane < SEL_WIDTH; lane++)
  begin : g_lane
    logic [7:0] mem_q [2**MEM_INDEX_WIDTH];
    logic [7:0] inst_byte_q;
    logic [7:0] data_byte_q;

    // write only the selected lane
    always_ff @(posedge clk)
    begin
      if (data_wr && data_sel_i[lane])
      begin
        mem_q[data_idx] <= data_dat_i[8*lane +: 8];
      end
    end

    // registered reads, old contents on a same-word write
    always_ff @(posedge clk)
    begin
      // fetch always takes the whole word
      inst_byte_q <= mem_q[inst_idx];
      // unselected lanes come back as zero
      if (data_sel_i[lane])
      begin
        data_byte_q <= mem_q[data_idx];
      end
      else
      begin
        data_byte_q <= 8'h00;
      end
    end

    assign inst_dat_o[8*lane +: 8] = inst_byte_q;
    assign data_dat_o[8*lane +: 8] = data_byte_q;
  end

endmodule

// File: inst_fetch_unit.sv
`timescale 1ns/1ps

module inst_fetch_unit (
  input  logic                     clk,
  input  logic                     reset_i,

  // run request
  input  logic                     start_i,
  input  wb_mem_pkg::wb_addr_t     start_pc_i,
  input  wb_mem_pkg::run_length_t  length_i,

  // queue occupancy, for credit
  input  wb_mem_pkg::queue_count_t q_count_i,

  // instruction port master
  output logic                     inst_cyc_o,
  output logic                     inst_stb_o,
  output wb_mem_pkg::wb_addr_t     inst_adr_o,
  input  logic                     inst_ack_i,
  input  wb_mem_pkg::wb_data_t     inst_dat_i,

  // queue write side
  output logic                     q_wr_en_o,
  output wb_mem_pkg::wb_data_t     q_wr_data_o
);
  import wb_mem_pkg::*;

  fetch_state_e               state_q;
  wb_addr_t                   next_adr_q;
  run_length_t                req_left_q;
  queue_count_t               inflight_q;
  // one extra bit so the sum cannot wrap
  logic [QUEUE_COUNT_WIDTH:0] credit_used;
  logic                       credit_ok;
  logic                       issue;
  logic                       drain_done;
  logic                       start_ok;

  // words already queued plus words still on the bus
  assign credit_used = {1'b0, q_count_i} + {1'b0, inflight_q};
  assign credit_ok   = credit_used < FETCH_QUEUE_DEPTH;

  // one request per cycle while credit lasts
  assign issue = (state_q == FETCH_REQ) && credit_ok;

  // run is over once nothing is in flight and the issue stage emptied the queue
  // this lines up with the cycle where busy has just dropped
  assign drain_done = (state_q == FETCH_DRAIN) && (inflight_q == '0) && (q_count_i == '0);

  // same start rule as the issue stage
  assign start_ok = start_i && (length_i != '0) &&
                    ((state_q == FETCH_IDLE) || drain_done);

  // state machine
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state_q <= FETCH_IDLE;
    end
    else
    begin
      case (state_q)
        FETCH_IDLE:
        begin
          if (start_ok)
          begin
            state_q <= FETCH_REQ;
          end
        end
        FETCH_REQ:
        begin
          // last request going out
          if (issue && (req_left_q == run_length_t'(1)))
          begin
            state_q <= FETCH_DRAIN;
          end
        end
        FETCH_DRAIN:
        begin
          if (start_ok)
          begin
            state_q <= FETCH_REQ;
          end
          else if (drain_done)
          begin
            state_q <= FETCH_IDLE;
          end
        end
        default:
        begin
          state_q <= FETCH_IDLE;
        end
      endcase
    end
  end

  // requests still to send
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      req_left_q <= '0;
    end
    else if (start_ok)
    begin
      req_left_q <= length_i;
    end
    else if (issue)
    begin
      req_left_q <= req_left_q - run_length_t'(1);
    end
  end

  // next word address, steps one word per request
  always_ff @(posedge clk)
  begin
    if (start_ok)
    begin
      next_adr_q <= start_pc_i;
    end
    else if (issue)
    begin
      next_adr_q <= next_adr_q + wb_addr_t'(SEL_WIDTH);
    end
  end

  // responses outstanding
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      inflight_q <= '0;
    end
    else
    begin
      case ({issue, inst_ack_i})
        2'b10:   inflight_q <= inflight_q + queue_count_t'(1);
        2'b01:   inflight_q <= inflight_q - queue_count_t'(1);
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  // cyc held while requesting or waiting on acks
  assign inst_cyc_o = (state_q == FETCH_REQ) || (inflight_q != '0);
  assign inst_stb_o = issue;
  assign inst_adr_o = next_adr_q;

  // every ack goes straight into the queue
  assign q_wr_en_o   = inst_ack_i;
  assign q_wr_data_o = inst_dat_i;

endmodule

// File: fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue (
  input  logic                     clk,
  input  logic                     reset_i,

  // write side, from the fetch unit
  input  logic                     wr_en_i,
  input  wb_mem_pkg::wb_data_t     wr_data_i,

  // read side, head shown ahead
  input  logic                     rd_en_i,
  output wb_mem_pkg::wb_data_t     rd_data_o,
  output logic                     empty_o,
  output wb_mem_pkg::queue_count_t count_o
);
  import wb_mem_pkg::*;

  wb_data_t     mem_q [FETCH_QUEUE_DEPTH];
  logic [$clog2(FETCH_QUEUE_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(FETCH_QUEUE_DEPTH)-1:0] rd_ptr_q;
  queue_count_t count_q;
  logic         do_rd;

  // pop only real entries
  assign do_rd = rd_en_i && (count_q != '0);

  // storage, no overflow check since the producer holds credit
  always_ff @(posedge clk)
  begin
    if (wr_en_i)
    begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  // pointers wrap at the depth
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (wr_en_i)
      begin
        wr_ptr_q <= (wr_ptr_q == FETCH_QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_rd)
      begin
        rd_ptr_q <= (rd_ptr_q == FETCH_QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // occupancy, push and pop together leave it unchanged
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      count_q <= '0;
    end
    else
    begin
      case ({wr_en_i, do_rd})
        2'b10:   count_q <= count_q + queue_count_t'(1);
        2'b01:   count_q <= count_q - queue_count_t'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // head word, valid whenever not empty
  assign rd_data_o = mem_q[rd_ptr_q];
  assign empty_o   = (count_q == '0);
  assign count_o   = count_q;

endmodule

// File: inst_issue_stage.sv
`timescale 1ns/1ps

module inst_issue_stage (
  input  logic                    clk,
  input  logic                    reset_i,

  // run request
  input  logic                    start_i,
  input  wb_mem_pkg::wb_addr_t    start_pc_i,
  input  wb_mem_pkg::run_length_t length_i,

  // queue read side
  input  logic                    q_empty_i,
  input  wb_mem_pkg::wb_data_t    q_rd_data_i,
  output logic                    q_rd_en_o,

  // output handshake
  output logic                    inst_valid_o,
  output wb_mem_pkg::wb_data_t    inst_word_o,
  output wb_mem_pkg::wb_addr_t    inst_pc_o,
  input  logic                    inst_ready_i,

  // run status
  output logic                    busy_o,
  output logic                    done_o
);
  import wb_mem_pkg::*;

  logic        busy_q;
  logic        done_q;
  wb_addr_t    pc_q;
  run_length_t remaining_q;
  logic        start_ok;
  logic        fire;

  // starts are dropped while busy or with zero length
  assign start_ok = start_i && !busy_q && (length_i != '0);

  // valid straight from the queue head
  assign inst_valid_o = busy_q && !q_empty_i;
  assign fire         = inst_valid_o && inst_ready_i;

  // run status and word count
  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      remaining_q <= '0;
    end
    else
    begin
      // done lasts one cycle
      done_q <= 1'b0;
      if (start_ok)
      begin
        busy_q      <= 1'b1;
        remaining_q <= length_i;
      end
      else if (fire)
      begin
        remaining_q <= remaining_q - run_length_t'(1);
        // final word, busy drops together with done
        if (remaining_q == run_length_t'(1))
        begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // pc of the head word
  always_ff @(posedge clk)
  begin
    if (start_ok)
    begin
      pc_q <= start_pc_i;
    end
    else if (fire)
    begin
      pc_q <= pc_q + wb_addr_t'(SEL_WIDTH);
    end
  end

  // head and pc hold while stalled on ready
  assign q_rd_en_o   = fire;
  assign inst_word_o = q_rd_data_i;
  assign inst_pc_o   = pc_q;
  assign busy_o      = busy_q;
  assign done_o      = done_q;

endmodule

// File: fetch_subsystem_top.sv
`timescale 1ns/1ps

module fetch_subsystem_top (
  input  logic                    clk,
  input  logic                    reset_i,

  // run interface
  input  logic                    start_i,
  input  wb_mem_pkg::wb_addr_t    start_pc_i,
  input  wb_mem_pkg::run_length_t length_i,
  output logic                    busy_o,
  output logic                    done_o,

  // data port slave, load/store side
  input  logic                    data_cyc_i,
  input  logic                    data_stb_i,
  input  logic                    data_we_i,
  input  wb_mem_pkg::wb_addr_t    data_adr_i,
  input  wb_mem_pkg::wb_sel_t     data_sel_i,
  input  wb_mem_pkg::wb_data_t    data_dat_i,
  output logic                    data_ack_o,
  output wb_mem_pkg::wb_data_t    data_dat_o,

  // issued words
  output logic                    inst_valid_o,
  output wb_mem_pkg::wb_data_t    inst_word_o,
  output wb_mem_pkg::wb_addr_t    inst_pc_o,
  input  logic                    inst_ready_i
);
  import wb_mem_pkg::*;

  // instruction bus between fetch unit and ram
  logic         inst_cyc;
  logic         inst_stb;
  wb_addr_t     inst_adr;
  logic         inst_ack;
  wb_data_t     inst_dat;

  // queue links
  logic         q_wr_en;
  wb_data_t     q_wr_data;
  queue_count_t q_count;
  logic         q_empty;
  wb_data_t     q_rd_data;
  logic         q_rd_en;

  dual_port_ram dual_port_ram_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .inst_cyc_i (inst_cyc),
    .inst_stb_i (inst_stb),
    .inst_adr_i (inst_adr),
    .inst_ack_o (inst_ack),
    .inst_dat_o (inst_dat),
    .data_cyc_i (data_cyc_i),
    .data_stb_i (data_stb_i),
    .data_we_i  (data_we_i),
    .data_adr_i (data_adr_i),
    .data_sel_i (data_sel_i),
    .data_dat_i (data_dat_i),
    .data_ack_o (data_ack_o),
    .data_dat_o (data_dat_o)
  );

  inst_fetch_unit inst_fetch_unit_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .start_pc_i  (start_pc_i),
    .length_i    (length_i),
    .q_count_i   (q_count),
    .inst_cyc_o  (inst_cyc),
    .inst_stb_o  (inst_stb),
    .inst_adr_o  (inst_adr),
    .inst_ack_i  (inst_ack),
    .inst_dat_i  (inst_dat),
    .q_wr_en_o   (q_wr_en),
    .q_wr_data_o (q_wr_data)
  );

  fetch_queue fetch_queue_inst (
    .clk       (clk),
    .reset_i   (reset_i),
    .wr_en_i   (q_wr_en),
    .wr_data_i (q_wr_data),
    .rd_en_i   (q_rd_en),
    .rd_data_o (q_rd_data),
    .empty_o   (q_empty),
    .count_o   (q_count)
  );

  inst_issue_stage inst_issue_stage_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .start_i      (start_i),
    .start_pc_i   (start_pc_i),
    .length_i     (length_i),
    .q_empty_i    (q_empty),
    .q_rd_data_i  (q_rd_data),
    .q_rd_en_o    (q_rd_en),
    .inst_valid_o (inst_valid_o),
    .inst_word_o  (inst_word_o),
    .inst_pc_o    (inst_pc_o),
    .inst_ready_i (inst_ready_i),
    .busy_o       (busy_o),
    .done_o       (done_o)
  );

endmodule

// File: tb_fetch_subsystem.sv
`timescale 1ns/1ps

module tb_fetch_subsystem;
  import wb_mem_pkg::*;

  logic        clk;
  logic        reset_i;
  logic        start_i;
  wb_addr_t    start_pc_i;
  run_length_t length_i;
  logic        busy_o;
  logic        done_o;
  logic        data_cyc_i;
  logic        data_stb_i;
  logic        data_we_i;
  wb_addr_t    data_adr_i;
  wb_sel_t     data_sel_i;
  wb_data_t    data_dat_i;
  logic        data_ack_o;
  wb_data_t    data_dat_o;
  logic        inst_valid_o;
  wb_data_t    inst_word_o;
  wb_addr_t    inst_pc_o;
  logic        inst_ready_i;

  // byte copy of the ram indexed by word index times lane count
  logic [7:0]  mem_model [2**MEM_INDEX_WIDTH * SEL_WIDTH];
  // words and pcs the DUT still owes in order
  wb_data_t    exp_words [$];
  wb_addr_t    exp_pcs [$];
  logic        done_expected;
  // previous cycle stalled and what it showed
  logic        stalled_q;
  wb_data_t    held_word;
  wb_addr_t    held_pc;

  fetch_subsystem_top fetch_subsystem_top_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .start_i      (start_i),
    .start_pc_i   (start_pc_i),
    .length_i     (length_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .data_cyc_i   (data_cyc_i),
    .data_stb_i   (data_stb_i),
    .data_we_i    (data_we_i),
    .data_adr_i   (data_adr_i),
    .data_sel_i   (data_sel_i),
    .data_dat_i   (data_dat_i),
    .data_ack_o   (data_ack_o),
    .data_dat_o   (data_dat_o),
    .inst_valid_o (inst_valid_o),
    .inst_word_o  (inst_word_o),
    .inst_pc_o    (inst_pc_o),
    .inst_ready_i (inst_ready_i)
  );

  // 20 ns clock
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  // model index of one lane byte
  // upper address bits drop out as in the ram
  function automatic int model_index(input wb_addr_t adr, input int lane);
    return int'(adr[MEM_INDEX_WIDTH+1:2]) * SEL_WIDTH + lane;
  endfunction

  // selected lanes from the model and zero elsewhere
  function automatic wb_data_t model_read(input wb_addr_t adr, input wb_sel_t sel);
    wb_data_t word;
    int       lane;
    word = '0;
    for (lane = 0; lane < SEL_WIDTH; lane++)
    begin
      if (sel[lane])
      begin
        word[8*lane +: 8] = mem_model[model_index(adr, lane)];
      end
    end
    return word;
  endfunction

  // ack exactly one cycle after each request and never otherwise
  assert property (@(posedge clk) disable iff (reset_i)
                   (data_cyc_i && data_stb_i) |=> data_ack_o)
    else report_failure("[ERROR] data_ack_o got 0x0, expected 0x1 after a request");
  assert property (@(posedge clk) disable iff (reset_i)
                   !(data_cyc_i && data_stb_i) |=> !data_ack_o)
    else report_failure("[ERROR] data_ack_o got 0x1, expected 0x0 with no request");
  // busy drops in the done cycle
  assert property (@(posedge clk) disable iff (reset_i) done_o |-> !busy_o)
    else report_failure("[ERROR] busy_o got 0x1, expected 0x0 while done_o is high");

  // output side sees the values of the cycle that just ended
  always @(posedge clk)
  begin
    if (!reset_i)
    begin
      assert (done_o === done_expected)
      else report_failure($sformatf("[ERROR] done_o got 0x%h, expected 0x%h",
                                    done_o, done_expected));
      if (stalled_q)
      begin
        assert (inst_valid_o === 1'b1)
        else report_failure($sformatf("[ERROR] inst_valid_o got 0x%h while stalled, expected 0x1",
                                      inst_valid_o));
        assert (inst_word_o === held_word)
        else report_failure($sformatf("[ERROR] inst_word_o got 0x%h while stalled, expected 0x%h",
                                      inst_word_o, held_word));
        assert (inst_pc_o === held_pc)
        else report_failure($sformatf("[ERROR] inst_pc_o got 0x%h while stalled, expected 0x%h",
                                      inst_pc_o, held_pc));
      end
      done_expected = 1'b0;
      if (inst_valid_o && inst_ready_i)
      begin
        assert (exp_words.size() != 0)
        else report_failure($sformatf("word 0x%h at pc 0x%h was delivered with no run pending",
                                      inst_word_o, inst_pc_o));
        assert (inst_pc_o === exp_pcs[0])
        else report_failure($sformatf("[ERROR] inst_pc_o got 0x%h, expected 0x%h",
                                      inst_pc_o, exp_pcs[0]));
        assert (inst_word_o === exp_words[0])
        else report_failure($sformatf("[ERROR] inst_word_o got 0x%h, expected 0x%h",
                                      inst_word_o, exp_words[0]));
        exp_words.delete(0);
        exp_pcs.delete(0);
        // done is due the cycle after the last word
        done_expected = (exp_words.size() == 0);
      end
      stalled_q = inst_valid_o && !inst_ready_i;
      held_word = inst_word_o;
      held_pc   = inst_pc_o;
    end
  end

  task automatic check_idle_outputs(input string when);
    assert ({data_ack_o, inst_valid_o, busy_o, done_o} === 4'h0)
    else report_failure($sformatf(
      "[ERROR] {data_ack_o,inst_valid_o,busy_o,done_o} %s: got 0x%h, expected 0x0",
      when, {data_ack_o, inst_valid_o, busy_o, done_o}));
  endtask

  // one write per call and back to back until data_idle
  task automatic data_write(input wb_addr_t adr, input wb_sel_t sel, input wb_data_t dat);
    int lane;
    data_cyc_i = 1'b1;
    data_stb_i = 1'b1;
    data_we_i  = 1'b1;
    data_adr_i = adr;
    data_sel_i = sel;
    data_dat_i = dat;
    for (lane = 0; lane < SEL_WIDTH; lane++)
    begin
      if (sel[lane])
      begin
        mem_model[model_index(adr, lane)] = dat[8*lane +: 8];
      end
    end
    @(posedge clk);
    #2;
  endtask

  task automatic data_idle();
    data_cyc_i = 1'b0;
    data_stb_i = 1'b0;
    data_we_i  = 1'b0;
  endtask

  task automatic data_read(input wb_addr_t adr, input wb_sel_t sel);
    int       waited;
    wb_data_t expected;
    data_cyc_i = 1'b1;
    data_stb_i = 1'b1;
    data_we_i  = 1'b0;
    data_adr_i = adr;
    data_sel_i = sel;
    @(posedge clk);
    #2;
    data_idle();
    waited = 0;
    while (!data_ack_o && waited < 8)
    begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!data_ack_o)
    begin
      report_failure($sformatf("timeout: read of address 0x%h was never acknowledged", adr));
    end
    expected = model_read(adr, sel);
    assert (data_dat_o === expected)
    else report_failure($sformatf("[ERROR] data_dat_o at 0x%h sel 0x%h: got 0x%h, expected 0x%h",
                                  adr, sel, data_dat_o, expected));
  endtask

  // one run from start to done that returns in the done cycle
  task automatic fetch_run(input wb_addr_t pc, input run_length_t len, input bit random_ready);
    int  k;
    int  cycles;
    bit  seen_valid;
    bit  seen_done;
    for (k = 0; k < int'(len); k++)
    begin
      exp_words.push_back(model_read(pc + wb_addr_t'(4 * k), 4'hF));
      exp_pcs.push_back(pc + wb_addr_t'(4 * k));
    end
    inst_ready_i = 1'b1;
    start_i      = 1'b1;
    start_pc_i   = pc;
    length_i     = len;
    @(posedge clk);
    #2;
    start_i = 1'b0;
    assert (busy_o === 1'b1)
    else report_failure($sformatf("[ERROR] busy_o got 0x%h after start, expected 0x1", busy_o));
    cycles     = 1;
    seen_valid = 1'b0;
    seen_done  = 1'b0;
    while (!seen_done && cycles < 2000)
    begin
      // never stalled so the first word comes three cycles after start
      if (!random_ready && !seen_valid && inst_valid_o)
      begin
        assert (cycles == 3)
        else report_failure($sformatf("inst_valid_o rose %0d cycles after start, expected 3",
                                      cycles));
        seen_valid = 1'b1;
      end
      if (random_ready)
      begin
        inst_ready_i = 1'($urandom_range(0, 1));
      end
      // a start in the middle of a run must be dropped
      if (random_ready && cycles == 5 && busy_o)
      begin
        start_i    = 1'b1;
        start_pc_i = $urandom & ~32'h3;
        length_i   = run_length_t'($urandom_range(1, 20));
      end
      else
      begin
        start_i = 1'b0;
      end
      @(posedge clk);
      #2;
      cycles++;
      seen_done = done_o;
    end
    start_i = 1'b0;
    if (!seen_done)
    begin
      report_failure($sformatf("timeout: done_o never pulsed for the run at pc 0x%h", pc));
    end
    assert (exp_words.size() == 0)
    else report_failure($sformatf("run at pc 0x%h ended with %0d words never delivered",
                                  pc, exp_words.size()));
  endtask

  // nothing may come out of a zero length start
  task automatic zero_length_start();
    int n;
    inst_ready_i = 1'b1;
    start_i      = 1'b1;
    start_pc_i   = $urandom & ~32'h3;
    length_i     = '0;
    @(posedge clk);
    #2;
    start_i = 1'b0;
    for (n = 0; n < 8; n++)
    begin
      assert (busy_o === 1'b0)
      else report_failure($sformatf(
        "[ERROR] busy_o got 0x%h after a zero length start, expected 0x0", busy_o));
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    int       i;
    wb_addr_t adr;
    wb_addr_t alias_adr;
    void'($urandom(22));
    reset_i       = 1'b1;
    start_i       = 1'b0;
    start_pc_i    = '0;
    length_i      = '0;
    // requests during reset must not be acknowledged
    data_cyc_i    = 1'b1;
    data_stb_i    = 1'b1;
    data_we_i     = 1'b0;
    data_adr_i    = '0;
    data_sel_i    = '0;
    data_dat_i    = '0;
    inst_ready_i  = 1'b0;
    done_expected = 1'b0;
    stalled_q     = 1'b0;
    held_word     = '0;
    held_pc       = '0;

    for (i = 0; i < 5; i++)
    begin
      @(posedge clk);
      #2;
      check_idle_outputs("during reset");
      // last reset cycle without a request
      if (i == 3)
      begin
        data_idle();
      end
    end
    reset_i = 1'b0;
    @(posedge clk);
    #2;
    check_idle_outputs("after reset");

    // fill every word with one request per cycle
    for (i = 0; i < 2**MEM_INDEX_WIDTH; i++)
    begin
      data_write(wb_addr_t'(i * SEL_WIDTH), 4'hF, $urandom);
    end
    // byte-laned writes anywhere with aliasing upper bits
    for (i = 0; i < 200; i++)
    begin
      data_write($urandom & ~32'h3, wb_sel_t'($urandom_range(0, 15)), $urandom);
    end
    data_idle();
    for (i = 0; i < 200; i++)
    begin
      data_read($urandom & ~32'h3, wb_sel_t'($urandom_range(0, 15)));
    end
    // write then read back through an alias above the index bits
    for (i = 0; i < 20; i++)
    begin
      adr = $urandom & ~32'h3;
      data_write(adr, 4'hF, $urandom);
      data_idle();
      alias_adr = adr ^ ($urandom_range(1, 255) << (MEM_INDEX_WIDTH + 2));
      data_read(alias_adr, 4'hF);
    end

    // ready high first and then random ready with a dropped start inside
    for (i = 0; i < 6; i++)
    begin
      fetch_run($urandom & ~32'h3, run_length_t'($urandom_range(1, 40)), 1'b0);
    end
    for (i = 0; i < 6; i++)
    begin
      fetch_run($urandom & ~32'h3, run_length_t'($urandom_range(1, 40)), 1'b1);
    end
    zero_length_start();
    fetch_run($urandom & ~32'h3, run_length_t'($urandom_range(1, 40)), 1'b0);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: compile.f
wb_mem_pkg.sv
dual_port_ram.sv
inst_fetch_unit.sv
fetch_queue.sv
inst_issue_stage.sv
fetch_subsystem_top.sv
tb_fetch_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch subsystem testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module tb_fetch_subsystem \
  --Mdir obj_dir -o sim_fetch_subsystem \
  -f compile.f

# $fatal in the testbench gives a nonzero exit status
./obj_dir/sim_fetch_subsystem
